// File: source/fe_mon_pkg.sv
package fe_mon_pkg;

    // Cause register width and CSR cause type
    localparam int XLEN = 64;
    typedef logic [XLEN-1:0] cause_t;          // The top bit flags an interrupt

    // Fetch addresses
    localparam int VA_IMPL = 39;             // Bits 63 down to VA_IMPL-1 must match
    localparam int PA_IMPL = 32;
    typedef logic [63:0] vaddr_t;
    typedef logic [39:0] paddr_t;

    // Any fetch physical address above this one is too big
    localparam paddr_t PA_MAX = paddr_t'({PA_IMPL{1'b1}}) - paddr_t'(1);

    typedef logic [39:0] pc_t;               // Execution stage PC
    typedef logic [1:0]  priv_lvl_t;

    localparam priv_lvl_t PRIV_U = 2'd0;
    localparam priv_lvl_t PRIV_S = 2'd1;

    localparam cause_t CAUSE_INSTR_ACCESS = cause_t'(1);
    localparam cause_t CAUSE_INSTR_PAGE   = cause_t'(12);

    localparam int ICACHE_WAYS = 4;

    // ITLB vectors carry one bit per entry
    localparam int TLB_ENTRIES = 16;
    typedef logic [TLB_ENTRIES-1:0] tlb_vec_t;

    // A fetch event collides with a flush up to WINDOW_SIZE-1 cycles later
    localparam int WINDOW_SIZE = 4;

    // BTB is indexed by PC bits 6 down to 1
    localparam int BTB_IDX_LSB = 1;
    localparam int BTB_IDX_MSB = 6;
    localparam int BTB_ENTRIES = 64;
    typedef logic [BTB_IDX_MSB-BTB_IDX_LSB:0] btb_idx_t;

    // Event groups
    localparam int NUM_SRC     = 4;          // Icache miss, icache hit, itlb miss, ifu dispatch
    localparam int NUM_FLUSH   = 4;          // Branch, exception, interrupt, icache flush
    localparam int NUM_COLL    = NUM_SRC * NUM_FLUSH;
    localparam int NUM_EXC     = 5;
    localparam int NUM_ITLB_EV = 3;

    localparam int EVENT_NUM = 25;
    typedef logic [EVENT_NUM-1:0] event_vec_t;

    // Counter read side
    localparam int CNT_SLOTS = 32;
    localparam int CNT_W     = 16;
    typedef logic [$clog2(CNT_SLOTS)-1:0] cnt_idx_t;
    typedef logic [CNT_W-1:0]             count_t;

    // Collisions sit at source*4 + flush in the counter index map
    localparam int EV_COLL_BASE  = 0;
    localparam int EV_EXC_BASE   = 16;       // Bad VA, upage, spage, too big PA, non exec
    localparam int EV_ITLB_FULL  = 21;
    localparam int EV_ITLB_MIXED = 22;
    localparam int EV_ITLB_MULTI = 23;
    localparam int EV_BTB_ALIAS  = 24;

endpackage

// File: source/fe_exception_classify.sv
module fe_exception_classify
    import fe_mon_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               fetch_req_i,
    input  vaddr_t             fetch_vaddr_i,
    input  paddr_t             fetch_paddr_i,
    input  logic               fetch_ex_valid_i,
    input  cause_t             fetch_ex_cause_i,
    input  priv_lvl_t          priv_lvl_i,
    input  logic               en_translation_i,
    input  logic               iaccess_err_i,       // U flag check failed on the instruction page
    input  logic               match_exec_region_i,
    output logic [NUM_EXC-1:0] exc_ev_o
);

    logic non_canonical;
    logic page_fault;
    logic access_fault;
    logic too_big_pa;
    logic [NUM_EXC-1:0] exc_d;

    // Upper VA bits must all be copies of bit VA_IMPL-1
    assign non_canonical = fetch_req_i &&
                           !((&fetch_vaddr_i[63:VA_IMPL-1]) || !(|fetch_vaddr_i[63:VA_IMPL-1]));

    assign page_fault   = fetch_ex_valid_i && (fetch_ex_cause_i == CAUSE_INSTR_PAGE);
    assign access_fault = fetch_ex_valid_i && (fetch_ex_cause_i == CAUSE_INSTR_ACCESS);
    assign too_big_pa   = fetch_paddr_i > PA_MAX;

    always_comb
    begin
        exc_d[0] = en_translation_i && non_canonical && page_fault;     // Bad VA
        // User page touched from S mode
        exc_d[1] = en_translation_i && iaccess_err_i && (priv_lvl_i == PRIV_S) && page_fault;
        // Supervisor page touched from U mode
        exc_d[2] = en_translation_i && iaccess_err_i && (priv_lvl_i == PRIV_U) && page_fault;
        exc_d[3] = too_big_pa && access_fault;
        exc_d[4] = !match_exec_region_i && !too_big_pa && access_fault;  // In range but not executable
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            exc_ev_o <= '0;
        end
        else
        begin
            exc_ev_o <= exc_d;
        end
    end

endmodule

// File: source/fe_collision_tracker.sv
module fe_collision_tracker
    import fe_mon_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [ICACHE_WAYS-1:0] cl_hit_i,
    input  logic                   icache_miss_i,
    input  logic                   itlb_miss_i,
    input  logic                   ifu_dispatch_valid_i,
    input  logic                   icache_flush_i,
    input  logic                   exe_valid_i,
    input  logic                   correct_branch_pred_i,
    input  logic                   stall_exe_i,
    input  logic                   id_valid_jal_i,
    input  logic                   csr_excpt_intrpt_i,
    input  cause_t                 csr_cause_i,
    output logic [NUM_COLL-1:0]    coll_ev_o
);

    logic [NUM_SRC-1:0]     src;
    logic [NUM_FLUSH-1:0]   flush;
    logic [NUM_SRC-1:0]     in_window;
    logic [NUM_COLL-1:0]    coll_d;
    logic [WINDOW_SIZE-2:0] hist_q [NUM_SRC];

    // Source order follows the counter index map
    assign src[0] = icache_miss_i;
    assign src[1] = |cl_hit_i;              // Any way hit
    assign src[2] = itlb_miss_i;
    assign src[3] = ifu_dispatch_valid_i;

    // Mispredicted branch resolved at EXE, or a JAL redirect from decode
    assign flush[0] = (exe_valid_i && !correct_branch_pred_i && !stall_exe_i) || id_valid_jal_i;
    assign flush[1] = csr_excpt_intrpt_i && !csr_cause_i[XLEN-1];
    assign flush[2] = csr_excpt_intrpt_i && csr_cause_i[XLEN-1];
    assign flush[3] = icache_flush_i;

    always_comb
    begin
        for (int s = 0; s < NUM_SRC; s++)
        begin
            in_window[s] = src[s] || (|hist_q[s]);
            for (int f = 0; f < NUM_FLUSH; f++)
            begin
                coll_d[s*NUM_FLUSH+f] = in_window[s] && flush[f];
            end
        end
    end

    // Bit 0 of each history holds the previous cycle, the top bit the oldest one
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            for (int s = 0; s < NUM_SRC; s++)
            begin
                hist_q[s] <= '0;
            end
            coll_ev_o <= '0;
        end
        else
        begin
            for (int s = 0; s < NUM_SRC; s++)
            begin
                hist_q[s] <= {hist_q[s][WINDOW_SIZE-3:0], src[s]};
            end
            coll_ev_o <= coll_d;
        end
    end

endmodule

// File: source/itlb_occupancy.sv
module itlb_occupancy
    import fe_mon_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   en_translation_i,
    input  tlb_vec_t               itlb_valid_i,
    input  tlb_vec_t               itlb_is_2m_i,
    input  tlb_vec_t               itlb_is_1g_i,
    input  tlb_vec_t               itlb_lu_hit_i,
    output logic [NUM_ITLB_EV-1:0] itlb_ev_o
);

    tlb_vec_t has_4k;
    tlb_vec_t has_2m;
    tlb_vec_t has_1g;
    logic     full;
    logic     mixed;
    logic     multi_hit;

    // A valid entry that is neither a 2M nor a 1G page maps a 4K page
    assign has_4k = itlb_valid_i & ~itlb_is_2m_i & ~itlb_is_1g_i;
    assign has_2m = itlb_valid_i & itlb_is_2m_i;
    assign has_1g = itlb_valid_i & itlb_is_1g_i;

    assign full  = &itlb_valid_i;
    assign mixed = full && (|has_4k) && (|has_2m) && (|has_1g);

    // Clearing the lowest set bit leaves something only if two or more hit
    assign multi_hit = |(itlb_lu_hit_i & (itlb_lu_hit_i - tlb_vec_t'(1)));

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            itlb_ev_o <= '0;
        end
        else
        begin
            itlb_ev_o[0]                            <= en_translation_i && full;
            itlb_ev_o[EV_ITLB_MIXED - EV_ITLB_FULL] <= en_translation_i && mixed;
            itlb_ev_o[EV_ITLB_MULTI - EV_ITLB_FULL] <= en_translation_i && multi_hit;
        end
    end

endmodule

// File: source/btb_alias_tracker.sv
module btb_alias_tracker
    import fe_mon_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic branch_at_exu_i,
    input  pc_t  pc_execution_i,
    output logic alias_ev_o
);

    logic [BTB_ENTRIES-1:0] valid_q;
    pc_t                    pc_q [BTB_ENTRIES];
    btb_idx_t               idx;
    logic                   alias_d;

    // Branches 128 bytes apart share an entry
    assign idx = pc_execution_i[BTB_IDX_MSB:BTB_IDX_LSB];

    assign alias_d = branch_at_exu_i && valid_q[idx] && (pc_q[idx] != pc_execution_i);

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            valid_q    <= '0;
            alias_ev_o <= 1'b0;
        end
        else
        begin
            alias_ev_o <= alias_d;
            if (branch_at_exu_i)
            begin
                valid_q[idx] <= 1'b1;
            end
        end
    end

    // Last branch PC seen per index
    always_ff @(posedge clk_i)
    begin
        if (branch_at_exu_i)
        begin
            pc_q[idx] <= pc_execution_i;    // Newer branch replaces the old owner
        end
    end

endmodule

// File: source/fe_counter_bank.sv
module fe_counter_bank
    import fe_mon_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       en_i,
    input  logic       clr_i,
    input  event_vec_t event_i,
    input  cnt_idx_t   rd_idx_i,
    output count_t     rd_data_o
);

    count_t cnt_q [EVENT_NUM];

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < EVENT_NUM; i++)
            begin
                cnt_q[i] <= '0;
            end
        end
        else if (clr_i)
        begin
            // Clear wins over any event arriving in the same cycle
            for (int i = 0; i < EVENT_NUM; i++)
            begin
                cnt_q[i] <= '0;
            end
        end
        else if (en_i)
        begin
            for (int i = 0; i < EVENT_NUM; i++)
            begin
                if (event_i[i] && (cnt_q[i] != '1))   // Stick at all ones
                begin
                    cnt_q[i] <= cnt_q[i] + count_t'(1);
                end
            end
        end
    end

    // Slots past the last event read as zero
    always_comb
    begin
        rd_data_o = '0;
        if (int'(rd_idx_i) < EVENT_NUM)
        begin
            rd_data_o = cnt_q[rd_idx_i];
        end
    end

endmodule

// File: source/fe_mon_top.sv
module fe_mon_top
    import fe_mon_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // Fetch request and exception
    input  logic                   fetch_req_i,
    input  vaddr_t                 fetch_vaddr_i,
    input  paddr_t                 fetch_paddr_i,
    input  logic                   fetch_ex_valid_i,
    input  cause_t                 fetch_ex_cause_i,
    input  priv_lvl_t              priv_lvl_i,
    input  logic                   en_translation_i,
    input  logic                   iaccess_err_i,
    input  logic                   match_exec_region_i,
    // Icache, ITLB and flush sources
    input  logic [ICACHE_WAYS-1:0] cl_hit_i,
    input  logic                   icache_miss_i,
    input  logic                   itlb_miss_i,
    input  logic                   ifu_dispatch_valid_i,
    input  logic                   icache_flush_i,
    input  logic                   exe_valid_i,
    input  logic                   correct_branch_pred_i,
    input  logic                   stall_exe_i,
    input  logic                   id_valid_jal_i,
    input  logic                   csr_excpt_intrpt_i,
    input  cause_t                 csr_cause_i,
    input  tlb_vec_t               itlb_valid_i,
    input  tlb_vec_t               itlb_is_2m_i,
    input  tlb_vec_t               itlb_is_1g_i,
    input  tlb_vec_t               itlb_lu_hit_i,
    input  logic                   branch_at_exu_i,
    input  pc_t                    pc_execution_i,
    // Counter control and readback
    input  logic                   en_i,
    input  logic                   clr_i,
    input  cnt_idx_t               rd_idx_i,
    output count_t                 rd_data_o
);

    event_vec_t ev_all;     // Each source drives its own slice of the index map

    fe_exception_classify u_exc (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .fetch_req_i         (fetch_req_i),
        .fetch_vaddr_i       (fetch_vaddr_i),
        .fetch_paddr_i       (fetch_paddr_i),
        .fetch_ex_valid_i    (fetch_ex_valid_i),
        .fetch_ex_cause_i    (fetch_ex_cause_i),
        .priv_lvl_i          (priv_lvl_i),
        .en_translation_i    (en_translation_i),
        .iaccess_err_i       (iaccess_err_i),
        .match_exec_region_i (match_exec_region_i),
        .exc_ev_o            (ev_all[EV_EXC_BASE +: NUM_EXC])
    );

    fe_collision_tracker u_coll (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .cl_hit_i              (cl_hit_i),
        .icache_miss_i         (icache_miss_i),
        .itlb_miss_i           (itlb_miss_i),
        .ifu_dispatch_valid_i  (ifu_dispatch_valid_i),
        .icache_flush_i        (icache_flush_i),
        .exe_valid_i           (exe_valid_i),
        .correct_branch_pred_i (correct_branch_pred_i),
        .stall_exe_i           (stall_exe_i),
        .id_valid_jal_i        (id_valid_jal_i),
        .csr_excpt_intrpt_i    (csr_excpt_intrpt_i),
        .csr_cause_i           (csr_cause_i),
        .coll_ev_o             (ev_all[EV_COLL_BASE +: NUM_COLL])
    );

    itlb_occupancy u_itlb (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .en_translation_i (en_translation_i),
        .itlb_valid_i     (itlb_valid_i),
        .itlb_is_2m_i     (itlb_is_2m_i),
        .itlb_is_1g_i     (itlb_is_1g_i),
        .itlb_lu_hit_i    (itlb_lu_hit_i),
        .itlb_ev_o        (ev_all[EV_ITLB_FULL +: NUM_ITLB_EV])
    );

    btb_alias_tracker u_btb (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .branch_at_exu_i (branch_at_exu_i),
        .pc_execution_i  (pc_execution_i),
        .alias_ev_o      (ev_all[EV_BTB_ALIAS])
    );

    fe_counter_bank u_cnt (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .en_i      (en_i),
        .clr_i     (clr_i),
        .event_i   (ev_all),
        .rd_idx_i  (rd_idx_i),
        .rd_data_o (rd_data_o)
    );

endmodule

// File: tests/fe_mon_model.svh
`ifndef FE_MON_MODEL_SVH
`define FE_MON_MODEL_SVH

int unsigned        m_cnt [EVENT_NUM];
event_vec_t         m_ev_q;                     // Events sampled at the previous edge
logic [NUM_SRC-1:0] m_hist [WINDOW_SIZE-1];     // Entry 0 is one cycle back
logic               m_btb_valid [BTB_ENTRIES];
pc_t                m_btb_pc [BTB_ENTRIES];

// Icache miss, icache hit, itlb miss, ifu dispatch from bit 0 upwards
function automatic logic [NUM_SRC-1:0] source_bits();
    return {ifu_dispatch_valid_i, itlb_miss_i, |cl_hit_i, icache_miss_i};
endfunction

function automatic event_vec_t expected_events();
    event_vec_t           ev;
    logic [NUM_SRC-1:0]   seen;
    logic [NUM_FLUSH-1:0] fl;
    logic                 canon;
    logic                 big;
    logic                 pf;
    logic                 af;
    logic                 has_4k;
    logic                 has_2m;
    logic                 has_1g;
    int                   hits;
    btb_idx_t             idx;

    canon = 1'b1;
    for (int i = VA_IMPL - 1; i < 64; i++)
    begin
        if (fetch_vaddr_i[i] != fetch_vaddr_i[63])
            canon = 1'b0;
    end
    big = 64'(fetch_paddr_i) > (64'd1 << PA_IMPL) - 64'd2;
    pf  = fetch_ex_valid_i && fetch_ex_cause_i == 64'd12;
    af  = fetch_ex_valid_i && fetch_ex_cause_i == 64'd1;
    ev  = '0;
    ev[EV_EXC_BASE]     = en_translation_i && fetch_req_i && !canon && pf;
    ev[EV_EXC_BASE + 1] = en_translation_i && iaccess_err_i && priv_lvl_i == 2'd1 && pf;
    ev[EV_EXC_BASE + 2] = en_translation_i && iaccess_err_i && priv_lvl_i == 2'd0 && pf;
    ev[EV_EXC_BASE + 3] = big && af;
    ev[EV_EXC_BASE + 4] = !match_exec_region_i && !big && af;

    // Branch, exception, interrupt and icache flush
    fl[0] = (exe_valid_i && !correct_branch_pred_i && !stall_exe_i) || id_valid_jal_i;
    fl[1] = csr_excpt_intrpt_i && !csr_cause_i[63];
    fl[2] = csr_excpt_intrpt_i && csr_cause_i[63];
    fl[3] = icache_flush_i;
    seen  = source_bits();
    for (int h = 0; h < WINDOW_SIZE - 1; h++)
        seen = seen | m_hist[h];
    for (int s = 0; s < NUM_SRC; s++)
    begin
        for (int f = 0; f < NUM_FLUSH; f++)
            ev[EV_COLL_BASE + s * NUM_FLUSH + f] = seen[s] && fl[f];
    end

    hits   = 0;
    has_4k = 1'b0;
    has_2m = 1'b0;
    has_1g = 1'b0;
    for (int e = 0; e < TLB_ENTRIES; e++)
    begin
        if (itlb_lu_hit_i[e])
            hits++;
        if (itlb_valid_i[e] && !itlb_is_2m_i[e] && !itlb_is_1g_i[e])
            has_4k = 1'b1;
        if (itlb_valid_i[e] && itlb_is_2m_i[e])
            has_2m = 1'b1;
        if (itlb_valid_i[e] && itlb_is_1g_i[e])
            has_1g = 1'b1;
    end
    ev[EV_ITLB_FULL]  = en_translation_i && itlb_valid_i == '1;
    ev[EV_ITLB_MIXED] = ev[EV_ITLB_FULL] && has_4k && has_2m && has_1g;
    ev[EV_ITLB_MULTI] = en_translation_i && hits > 1;

    idx = pc_execution_i[6:1];
    ev[EV_BTB_ALIAS] = branch_at_exu_i && m_btb_valid[idx] && m_btb_pc[idx] != pc_execution_i;
    return ev;
endfunction

task automatic reset_model();
    for (int i = 0; i < EVENT_NUM; i++)
        m_cnt[i] = 0;
    for (int h = 0; h < WINDOW_SIZE - 1; h++)
        m_hist[h] = '0;
    for (int b = 0; b < BTB_ENTRIES; b++)
        m_btb_valid[b] = 1'b0;
    m_ev_q = '0;
endtask

// Advances the model by one rising edge
task automatic step_model();
    event_vec_t ev_now;
    btb_idx_t   idx;

    ev_now = expected_events();
    if (clr_i)
    begin
        for (int i = 0; i < EVENT_NUM; i++)
            m_cnt[i] = 0;
    end
    else if (en_i)
    begin
        for (int i = 0; i < EVENT_NUM; i++)
        begin
            if (m_ev_q[i] && m_cnt[i] < (1 << CNT_W) - 1)
                m_cnt[i]++;
        end
    end
    m_ev_q = ev_now;                            // Counted at the next edge
    for (int h = WINDOW_SIZE - 2; h > 0; h--)
        m_hist[h] = m_hist[h - 1];
    m_hist[0] = source_bits();
    if (branch_at_exu_i)
    begin
        idx = pc_execution_i[6:1];
        m_btb_valid[idx] = 1'b1;
        m_btb_pc[idx]    = pc_execution_i;
    end
endtask

// Unused slots read zero
function automatic count_t expected_count(input int slot);
    if (slot < EVENT_NUM)
        return count_t'(m_cnt[slot]);
    return count_t'(0);
endfunction

`endif

// File: tests/fe_mon_tb.sv
module fe_mon_tb
    import fe_mon_pkg::*;
();

    localparam int STIM_CYCLES = 2000;
    localparam int SWEEP_EVERY = 200;
    localparam int SAT_CYCLES  = (1 << CNT_W) + 16;     // One event per cycle fills a counter
    localparam int MAX_CYCLES  = 5 + STIM_CYCLES + SAT_CYCLES
                                 + (STIM_CYCLES / SWEEP_EVERY + 4) * (CNT_SLOTS + 1) + 64;

    // Small stimulus sets so that every rule sees both outcomes
    localparam vaddr_t VADDR_SET [4] = '{64'h0000_0000_8000_1000, 64'hffff_ffc0_0000_2000,
                                         64'h0000_0040_0000_0000, 64'h8000_0000_0000_1000};
    localparam paddr_t PADDR_SET [4] = '{40'h00_8000_0000, 40'h00_ffff_fffe,
                                         40'h00_ffff_ffff, 40'h10_0000_0000};
    localparam cause_t CAUSE_SET [4] = '{64'd1, 64'd12, 64'd2, {1'b1, 63'd12}};
    localparam pc_t    PC_BASE       = 40'h00_8000_0000;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   fetch_req_i;
    vaddr_t                 fetch_vaddr_i;
    paddr_t                 fetch_paddr_i;
    logic                   fetch_ex_valid_i;
    cause_t                 fetch_ex_cause_i;
    priv_lvl_t              priv_lvl_i;
    logic                   en_translation_i;
    logic                   iaccess_err_i;
    logic                   match_exec_region_i;
    logic [ICACHE_WAYS-1:0] cl_hit_i;
    logic                   icache_miss_i;
    logic                   itlb_miss_i;
    logic                   ifu_dispatch_valid_i;
    logic                   icache_flush_i;
    logic                   exe_valid_i;
    logic                   correct_branch_pred_i;
    logic                   stall_exe_i;
    logic                   id_valid_jal_i;
    logic                   csr_excpt_intrpt_i;
    cause_t                 csr_cause_i;
    tlb_vec_t               itlb_valid_i;
    tlb_vec_t               itlb_is_2m_i;
    tlb_vec_t               itlb_is_1g_i;
    tlb_vec_t               itlb_lu_hit_i;
    logic                   branch_at_exu_i;
    pc_t                    pc_execution_i;
    logic                   en_i;
    logic                   clr_i;
    cnt_idx_t               rd_idx_i;
    count_t                 rd_data_o;

    logic [31:0] lfsr;
    logic        sat_mode;                              // Keeps the ITLB full every cycle
    int          cycle_cnt = 0;

    `include "fe_mon_model.svh"

    fe_mon_top uut (.*);

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic logic [63:0] next_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    // True once in 2**n draws
    function automatic logic one_in(input int n);
        return next_bits(n) == 64'd0;
    endfunction

    task automatic drive_random();
        fetch_req_i         = 1'(next_bits(1));
        fetch_vaddr_i       = VADDR_SET[2'(next_bits(2))];
        fetch_paddr_i       = PADDR_SET[2'(next_bits(2))];
        fetch_ex_valid_i    = 1'(next_bits(1));
        fetch_ex_cause_i    = CAUSE_SET[2'(next_bits(2))];
        priv_lvl_i          = priv_lvl_t'(next_bits(2));
        en_translation_i    = 1'(next_bits(1));
        iaccess_err_i       = 1'(next_bits(1));
        match_exec_region_i = 1'(next_bits(1));
        cl_hit_i            = 4'(next_bits(4));
        if (!one_in(2))
            cl_hit_i = '0;
        icache_miss_i         = one_in(2);
        itlb_miss_i           = one_in(2);
        ifu_dispatch_valid_i  = one_in(1);
        icache_flush_i        = one_in(3);
        exe_valid_i           = 1'(next_bits(1));
        correct_branch_pred_i = 1'(next_bits(1));
        stall_exe_i           = 1'(next_bits(1));
        id_valid_jal_i        = one_in(3);
        csr_excpt_intrpt_i    = one_in(3);
        csr_cause_i           = next_bits(4);
        csr_cause_i[63]       = 1'(next_bits(1));       // Interrupt or exception flush
        itlb_valid_i          = 16'(next_bits(16));
        if (one_in(1))
            itlb_valid_i = '1;
        itlb_is_2m_i = 16'(next_bits(16));
        itlb_is_1g_i = 16'(next_bits(16));
        if (one_in(1))
            itlb_is_1g_i = '0;
        itlb_lu_hit_i = 16'(next_bits(16));
        if (one_in(1))
            itlb_lu_hit_i = tlb_vec_t'(1) << 4'(next_bits(4));
        branch_at_exu_i = 1'(next_bits(1));
        // PCs 128 bytes apart land on the same BTB index
        pc_execution_i      = PC_BASE + (pc_t'(next_bits(3)) << 7);
        pc_execution_i[2:1] = 2'(next_bits(2));
        if (sat_mode)
        begin
            en_translation_i = 1'b1;
            itlb_valid_i     = '1;
        end
    endtask

    task automatic check_value(input int slot, input count_t got, input count_t exp);
        if (got !== exp)
        begin
            $display("FAIL t=%0t slot %0d read 0x%0h, expected 0x%0h", $time, slot, got, exp);
            $display("sim failed");
            $fatal(1, "Counter readback mismatch");
        end
    endtask

    // Reads one slot per falling edge while counting is paused
    task automatic sweep(input logic expect_zero);
        count_t exp;
        en_i = 1'b0;
        for (int s = 0; s < CNT_SLOTS; s++)
        begin
            rd_idx_i = cnt_idx_t'(s);
            drive_random();
            @(negedge clk_i);
            exp = expect_zero ? count_t'(0) : expected_count(s);
            check_value(s, rd_data_o, exp);
        end
        en_i = 1'b1;
    endtask

    always @(posedge clk_i)
    begin
        if (!rst_n_i)
            reset_model();
        else
            step_model();
    end

    always @(posedge clk_i)
    begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES)
        begin
            $display("sim failed");
            $fatal(1, "Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    initial
    begin
        clk_i    = 1'b0;
        rst_n_i  = 1'b0;
        en_i     = 1'b0;
        clr_i    = 1'b0;
        rd_idx_i = '0;
        sat_mode = 1'b0;
        lfsr     = 32'h24b1;
        drive_random();
        repeat (5) @(negedge clk_i);
        rst_n_i = 1'b1;
        sweep(1'b1);
        for (int c = 1; c <= STIM_CYCLES; c++)
        begin
            drive_random();
            @(negedge clk_i);
            if (c % SWEEP_EVERY == 0)
                sweep(1'b0);
            if (c == STIM_CYCLES / 2)
            begin
                clr_i = 1'b1;
                drive_random();
                @(negedge clk_i);
                clr_i = 1'b0;
                sweep(1'b1);                            // Every slot is back at zero
            end
        end

        // Slot 21 fires every cycle from here on and must stick at all ones
        sat_mode = 1'b1;
        repeat (SAT_CYCLES)
        begin
            drive_random();
            @(negedge clk_i);
        end
        en_i     = 1'b0;
        rd_idx_i = cnt_idx_t'(EV_ITLB_FULL);
        @(negedge clk_i);
        check_value(EV_ITLB_FULL, rd_data_o, {CNT_W{1'b1}});
        sweep(1'b0);
        $display("sim passed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+tests
source/fe_mon_pkg.sv
source/fe_exception_classify.sv
source/fe_collision_tracker.sv
source/itlb_occupancy.sv
source/btb_alias_tracker.sv
source/fe_counter_bank.sv
source/fe_mon_top.sv
tests/fe_mon_tb.sv

// File: Makefile
# Verilator build of the frontend event monitor testbench

VERILATOR ?= verilator
TOP       ?= fe_mon_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard source/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The binary exits non-zero when the testbench stops with $fatal
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
